/* vlog.f */
+incdir+src
src/fpga_wrapper_pkg.sv
src/sync_fifo.sv
src/realtime_regs.sv
src/itrng_source.sv
src/fpga_wrapper_top.sv
test/tb_fpga_wrapper.sv

/* test/tb_fpga_wrapper.sv */
`timescale 1ns/1ps
`include "fpga_wrapper_consts.svh"

module tb_fpga_wrapper;

    // Cycle budgets per test summed for the watchdog
    localparam int TEST_BUDGET     = 100 + 300 + 200 + 300 + 200 + 100;
    localparam int WATCHDOG_CYCLES = 2 * TEST_BUDGET;
    localparam int READ_TIMEOUT    = 20;
    localparam int CYCLE_GAP       = 10;

    logic                           core_clk;
    logic                           hwif_out;
    logic                           reg_wr_en;
    logic                           reg_rd_en;
    fpga_wrapper_pkg::reg_addr_t    reg_addr;
    fpga_wrapper_pkg::reg_data_t    reg_wdata;
    fpga_wrapper_pkg::reg_data_t    reg_rdata;
    logic                           reg_rd_valid;
    logic                           gen_out_wr;
    fpga_wrapper_pkg::log_char_t    gen_out_char;
    logic                           etrng_req;
    fpga_wrapper_pkg::trng_nibble_t itrng_data;
    logic                           itrng_valid;

    // Reference model state
    fpga_wrapper_pkg::log_char_t    log_model[$];
    fpga_wrapper_pkg::trng_nibble_t nib_model[$];
    fpga_wrapper_pkg::reg_data_t    rd_q[$];
    int                             pulse_times[$];
    int                             itrng_level;
    logic                           ctrl_model;
    logic                           rd_expected;
    logic [15:0]                    lfsr;
    int                             errors;
    int                             tests_run;
    int                             tests_failed;
    int                             cycle_num;

    fpga_wrapper_top fpga_wrapper_top_i (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .gen_out_wr   (gen_out_wr),
        .gen_out_char (gen_out_char),
        .etrng_req    (etrng_req),
        .itrng_data   (itrng_data),
        .itrng_valid  (itrng_valid)
    );

    initial begin
        core_clk = 1'b0;
        forever begin
            #10 core_clk = ~core_clk;
        end
    end

    always @(posedge core_clk) begin
        cycle_num <= cycle_num + 1;
    end

    // Galois LFSR with taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected value of a status or control read
    function automatic fpga_wrapper_pkg::reg_data_t ref_read(
        input fpga_wrapper_pkg::reg_addr_t addr);
        fpga_wrapper_pkg::reg_data_t v;
        v = '0;
        case (addr)
            `REG_CONTROL: v[0] = ctrl_model;
            `REG_LOG_STATUS: begin
                v[`STATUS_EMPTY_BIT] = (log_model.size() == 0);
                v[`STATUS_FULL_BIT]  = (log_model.size() == `LOG_FIFO_DEPTH);
            end
            `REG_ITRNG_STATUS: begin
                v[`STATUS_EMPTY_BIT] = (itrng_level == 0);
                v[`STATUS_FULL_BIT]  = (itrng_level == `ITRNG_FIFO_DEPTH);
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    task automatic check_reg(input string name, input fpga_wrapper_pkg::reg_data_t got,
                             input fpga_wrapper_pkg::reg_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_nibble(input string name, input fpga_wrapper_pkg::trng_nibble_t got,
                                input fpga_wrapper_pkg::trng_nibble_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_char(input string name, input fpga_wrapper_pkg::log_char_t got,
                              input fpga_wrapper_pkg::log_char_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Read data collector
    // Valid must follow the read strobe by exactly one cycle
    always @(negedge core_clk) begin
        if (hwif_out) begin
            check_reg("reg_rd_valid", reg_rd_valid, rd_expected);
            if (reg_rd_valid) begin
                rd_q.push_back(reg_rdata);
            end
            rd_expected = 1'b0;
        end
    end

    // Entropy compare process
    // Any pulse with nothing expected is an error
    always @(negedge core_clk) begin
        if (hwif_out && itrng_valid) begin
            pulse_times.push_back(cycle_num);
            if (nib_model.size() == 0) begin
                errors++;
                $display("Unexpected itrng_valid pulse with no nibble pending");
            end else begin
                // First nibble of a word means the word left the FIFO
                if (nib_model.size() % `NIBBLES_PER_WORD == 0 && itrng_level > 0) begin
                    itrng_level--;
                end
                check_nibble("itrng_data", itrng_data, nib_model.pop_front());
            end
        end
    end

    task automatic write_reg(input fpga_wrapper_pkg::reg_addr_t addr,
                             input fpga_wrapper_pkg::reg_data_t data);
        @(posedge core_clk);
        reg_wr_en <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge core_clk);
        reg_wr_en <= 1'b0;
        if (addr == `REG_ITRNG_DATA && itrng_level < `ITRNG_FIFO_DEPTH) begin
            itrng_level++;
            for (int i = 0; i < `NIBBLES_PER_WORD; i++) begin
                nib_model.push_back(data[4*i +: 4]);
            end
        end
        if (addr == `REG_CONTROL) begin
            ctrl_model = data[0];
            if (data[0]) begin
                itrng_level = 0;
                nib_model.delete();
            end
        end
    endtask

    task automatic push_char(input fpga_wrapper_pkg::log_char_t c);
        @(posedge core_clk);
        gen_out_wr   <= 1'b1;
        gen_out_char <= c;
        @(posedge core_clk);
        gen_out_wr   <= 1'b0;
        if (log_model.size() < `LOG_FIFO_DEPTH) begin
            log_model.push_back(c);
        end
    endtask

    task automatic strobe_read(input fpga_wrapper_pkg::reg_addr_t addr);
        @(posedge core_clk);
        reg_rd_en <= 1'b1;
        reg_addr  <= addr;
        @(posedge core_clk);
        reg_rd_en   <= 1'b0;
        rd_expected = 1'b1;
    endtask

    task automatic collect_read(output fpga_wrapper_pkg::reg_data_t v);
        int waited;
        waited = 0;
        while (rd_q.size() == 0 && waited < READ_TIMEOUT) begin
            @(negedge core_clk);
            waited++;
        end
        if (rd_q.size() == 0) begin
            errors++;
            $display("No read data returned within %0d cycles", READ_TIMEOUT);
            v = '0;
        end else begin
            v = rd_q.pop_front();
        end
    endtask

    task automatic read_check(input fpga_wrapper_pkg::reg_addr_t addr, input string name);
        fpga_wrapper_pkg::reg_data_t exp;
        fpga_wrapper_pkg::reg_data_t got;
        exp = ref_read(addr);
        strobe_read(addr);
        collect_read(got);
        check_reg(name, got, exp);
    endtask

    // Log data read where the character only counts with valid set
    task automatic read_log_data();
        fpga_wrapper_pkg::reg_data_t got;
        logic                        exp_valid;
        exp_valid = (log_model.size() != 0);
        strobe_read(`REG_LOG_DATA);
        collect_read(got);
        check_reg("reg_rdata log valid", got & (32'h1 << `LOG_VALID_BIT),
                  fpga_wrapper_pkg::reg_data_t'(exp_valid) << `LOG_VALID_BIT);
        if (exp_valid) begin
            check_char("reg_rdata log char", got[7:0], log_model.pop_front());
        end
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (nib_model.size() != 0 && n < max_cycles) begin
            @(posedge core_clk);
            n++;
        end
        if (nib_model.size() != 0) begin
            errors++;
            $display("Entropy stream stalled with %0d nibbles still expected", nib_model.size());
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("Watchdog expired after %0d cycles, the test sequence hung", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        fpga_wrapper_pkg::reg_data_t v1;
        fpga_wrapper_pkg::reg_data_t v2;
        int                          e0;
        hwif_out     = 1'b0;
        reg_wr_en    = 1'b0;
        reg_rd_en    = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        gen_out_wr   = 1'b0;
        gen_out_char = '0;
        etrng_req    = 1'b0;
        lfsr         = 16'd34454;
        itrng_level  = 0;
        ctrl_model   = 1'b0;
        rd_expected  = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_num    = 0;
        repeat (4) @(posedge core_clk);
        hwif_out <= 1'b1;

        e0 = errors;
        read_check(`REG_ITRNG_STATUS, "itrng status after reset");
        read_check(`REG_LOG_STATUS, "log status after reset");
        read_log_data();
        @(posedge core_clk);
        etrng_req <= 1'b1;
        repeat (20) @(posedge core_clk);
        etrng_req <= 1'b0;
        end_test("reset state", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            push_char(fpga_wrapper_pkg::log_char_t'(rand_bits(8)));
        end
        read_check(`REG_LOG_STATUS, "log status full");
        // 16 held characters and then one read with nothing left
        for (int i = 0; i < 17; i++) begin
            read_log_data();
        end
        read_check(`REG_LOG_STATUS, "log status drained");
        end_test("log capture and drain", e0);

        e0 = errors;
        write_reg(`REG_ITRNG_DIVISOR, 32'd0);
        for (int i = 0; i < 3; i++) begin
            write_reg(`REG_ITRNG_DATA, rand_bits(32));
        end
        etrng_req <= 1'b1;
        wait_drained(150);
        repeat (20) @(posedge core_clk);
        etrng_req <= 1'b0;
        end_test("entropy stream", e0);

        e0 = errors;
        write_reg(`REG_ITRNG_DIVISOR, 32'd5);
        for (int i = 0; i < 2; i++) begin
            write_reg(`REG_ITRNG_DATA, rand_bits(32));
        end
        pulse_times.delete();
        etrng_req <= 1'b1;
        wait_drained(200);
        etrng_req <= 1'b0;
        check_reg("itrng_valid pulse count", pulse_times.size(), 2 * `NIBBLES_PER_WORD);
        for (int i = 1; i < pulse_times.size(); i++) begin
            check_reg("itrng_valid spacing", pulse_times[i] - pulse_times[i-1], 32'd6);
        end
        end_test("throttle spacing", e0);

        e0 = errors;
        for (int i = 0; i < `ITRNG_FIFO_DEPTH; i++) begin
            write_reg(`REG_ITRNG_DATA, rand_bits(32));
        end
        read_check(`REG_ITRNG_STATUS, "itrng status full");
        write_reg(`REG_CONTROL, 32'd1);
        read_check(`REG_CONTROL, "control clear bit set");
        write_reg(`REG_CONTROL, 32'd0);
        read_check(`REG_CONTROL, "control clear bit released");
        read_check(`REG_ITRNG_STATUS, "itrng status cleared");
        @(posedge core_clk);
        etrng_req <= 1'b1;
        repeat (40) @(posedge core_clk);
        etrng_req <= 1'b0;
        end_test("fifo clear", e0);

        e0 = errors;
        strobe_read(`REG_CYCLE_COUNT);
        repeat (CYCLE_GAP - 2) @(posedge core_clk);
        strobe_read(`REG_CYCLE_COUNT);
        collect_read(v1);
        collect_read(v2);
        check_reg("cycle count delta", v2 - v1, CYCLE_GAP);
        end_test("cycle counter", e0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* src/fpga_wrapper_top.sv */
`timescale 1ns/1ps
`include "fpga_wrapper_consts.svh"

module fpga_wrapper_top (
    input  logic                           core_clk,
    input  logic                           hwif_out,

    // Register strobe bus
    input  logic                           reg_wr_en,
    input  logic                           reg_rd_en,
    input  fpga_wrapper_pkg::reg_addr_t    reg_addr,
    input  fpga_wrapper_pkg::reg_data_t    reg_wdata,
    output fpga_wrapper_pkg::reg_data_t    reg_rdata,
    output logic                           reg_rd_valid,

    // Generic output write from the core
    input  logic                           gen_out_wr,
    input  fpga_wrapper_pkg::log_char_t    gen_out_char,

    // Core entropy side
    input  logic                           etrng_req,
    output fpga_wrapper_pkg::trng_nibble_t itrng_data,
    output logic                           itrng_valid
);

    fpga_wrapper_pkg::log_char_t  log_char;
    logic                         log_empty;
    logic                         log_full;
    logic                         log_pop;
    logic                         itrng_word_wr;
    fpga_wrapper_pkg::trng_word_t itrng_word;
    logic                         itrng_clear;
    fpga_wrapper_pkg::reg_data_t  itrng_divisor;
    logic                         itrng_empty;
    logic                         itrng_full;

    realtime_regs realtime_regs_i (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .reg_wr_en     (reg_wr_en),
        .reg_rd_en     (reg_rd_en),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .reg_rd_valid  (reg_rd_valid),
        .log_char      (log_char),
        .log_empty     (log_empty),
        .log_full      (log_full),
        .log_pop       (log_pop),
        .itrng_word_wr (itrng_word_wr),
        .itrng_word    (itrng_word),
        .itrng_clear   (itrng_clear),
        .itrng_divisor (itrng_divisor),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full)
    );

    // Console log capture, never cleared by software
    sync_fifo #(
        .WIDTH ($bits(fpga_wrapper_pkg::log_char_t)),
        .DEPTH (`LOG_FIFO_DEPTH)
    ) log_fifo_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .clear    (1'b0),
        .push     (gen_out_wr),
        .din      (gen_out_char),
        .pop      (log_pop),
        .dout     (log_char),
        .empty    (log_empty),
        .full     (log_full)
    );

    itrng_source itrng_source_i (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .clear       (itrng_clear),
        .word_wr     (itrng_word_wr),
        .word        (itrng_word),
        .divisor     (itrng_divisor),
        .etrng_req   (etrng_req),
        .fifo_empty  (itrng_empty),
        .fifo_full   (itrng_full),
        .itrng_data  (itrng_data),
        .itrng_valid (itrng_valid)
    );

endmodule

/* src/itrng_source.sv */
`timescale 1ns/1ps
`include "fpga_wrapper_consts.svh"

module itrng_source (
    input  logic                           core_clk,
    input  logic                           hwif_out,
    input  logic                           clear,
    input  logic                           word_wr,
    input  fpga_wrapper_pkg::trng_word_t   word,
    input  fpga_wrapper_pkg::reg_data_t    divisor,
    input  logic                           etrng_req,
    output logic                           fifo_empty,
    output logic                           fifo_full,
    output fpga_wrapper_pkg::trng_nibble_t itrng_data,
    output logic                           itrng_valid
);

    localparam int NIB_W = $bits(fpga_wrapper_pkg::trng_nibble_t);
    localparam int CNT_W = $clog2(`NIBBLES_PER_WORD);

    fpga_wrapper_pkg::trng_state_e  state;
    fpga_wrapper_pkg::trng_word_t   shift_reg;
    logic [CNT_W-1:0]               nib_left;
    fpga_wrapper_pkg::reg_data_t    throttle_cnt;
    fpga_wrapper_pkg::trng_word_t   fifo_dout;
    fpga_wrapper_pkg::trng_nibble_t cur_nibble;
    logic                           req_sample;
    logic                           take;
    logic                           fifo_pop;

    sync_fifo #(
        .WIDTH ($bits(fpga_wrapper_pkg::trng_word_t)),
        .DEPTH (`ITRNG_FIFO_DEPTH)
    ) word_fifo_i (
        .core_clk (core_clk),
        .hwif_out (hwif_out),
        .clear    (clear),
        .push     (word_wr),
        .din      (word),
        .pop      (fifo_pop),
        .dout     (fifo_dout),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    // Request is looked at only when the throttle counter hits zero
    assign req_sample = (throttle_cnt == '0) && etrng_req;

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt <= divisor;
        end else begin
            throttle_cnt <= throttle_cnt - 1'b1;
        end
    end

    // With no word held the first nibble comes straight from the FIFO head
    assign take = req_sample && !clear &&
                  ((state == fpga_wrapper_pkg::TRNG_SHIFT) || !fifo_empty);
    assign fifo_pop   = take && (state == fpga_wrapper_pkg::TRNG_EMPTY);
    assign cur_nibble = (state == fpga_wrapper_pkg::TRNG_SHIFT) ?
                        shift_reg[NIB_W-1:0] : fifo_dout[NIB_W-1:0];

    // Word unpacker, least significant nibble first
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            state     <= fpga_wrapper_pkg::TRNG_EMPTY;
            shift_reg <= '0;
            nib_left  <= '0;
        end else if (clear) begin
            state    <= fpga_wrapper_pkg::TRNG_EMPTY;
            nib_left <= '0;
        end else if (take) begin
            if (state == fpga_wrapper_pkg::TRNG_EMPTY) begin
                shift_reg <= fifo_dout >> NIB_W;
                nib_left  <= CNT_W'(`NIBBLES_PER_WORD - 1);
                state     <= fpga_wrapper_pkg::TRNG_SHIFT;
            end else begin
                shift_reg <= shift_reg >> NIB_W;
                nib_left  <= nib_left - 1'b1;
                // Last nibble of this word
                if (nib_left == CNT_W'(1)) begin
                    state <= fpga_wrapper_pkg::TRNG_EMPTY;
                end
            end
        end
    end

    // One-cycle valid pulse toward the core
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            itrng_valid <= 1'b0;
            itrng_data  <= '0;
        end else begin
            itrng_valid <= take;
            if (take) begin
                itrng_data <= cur_nibble;
            end
        end
    end

endmodule

/* src/realtime_regs.sv */
`timescale 1ns/1ps
`include "fpga_wrapper_consts.svh"

module realtime_regs (
    // Register strobe bus
    input  logic                          core_clk,
    input  logic                          hwif_out,
    input  logic                          reg_wr_en,
    input  logic                          reg_rd_en,
    input  fpga_wrapper_pkg::reg_addr_t   reg_addr,
    input  fpga_wrapper_pkg::reg_data_t   reg_wdata,
    output fpga_wrapper_pkg::reg_data_t   reg_rdata,
    output logic                          reg_rd_valid,

    // Log FIFO
    input  fpga_wrapper_pkg::log_char_t   log_char,
    input  logic                          log_empty,
    input  logic                          log_full,
    output logic                          log_pop,

    // Itrng source
    output logic                          itrng_word_wr,
    output fpga_wrapper_pkg::trng_word_t  itrng_word,
    output logic                          itrng_clear,
    output fpga_wrapper_pkg::reg_data_t   itrng_divisor,
    input  logic                          itrng_empty,
    input  logic                          itrng_full
);

    logic                           ctrl_itrng_clear;
    fpga_wrapper_pkg::reg_data_t    divisor_q;
    fpga_wrapper_pkg::cycle_count_t cycle_count;
    fpga_wrapper_pkg::reg_data_t    rd_value;
    logic                           wr_control;
    logic                           wr_divisor;

    // Write decode
    assign wr_control    = reg_wr_en && (reg_addr == `REG_CONTROL);
    assign wr_divisor    = reg_wr_en && (reg_addr == `REG_ITRNG_DIVISOR);
    assign itrng_word_wr = reg_wr_en && (reg_addr == `REG_ITRNG_DATA);
    assign itrng_word    = reg_wdata;

    assign itrng_clear   = ctrl_itrng_clear;
    assign itrng_divisor = divisor_q;

    // Pop only when a character is actually consumed by this read
    assign log_pop = reg_rd_en && (reg_addr == `REG_LOG_DATA) && !log_empty;

    // Read mux, unmapped offsets return zero
    always_comb begin
        rd_value = '0;
        case (reg_addr)
            `REG_CONTROL: begin
                rd_value[`CTRL_ITRNG_CLEAR_BIT] = ctrl_itrng_clear;
            end
            `REG_ITRNG_DIVISOR: begin
                rd_value = divisor_q;
            end
            `REG_ITRNG_STATUS: begin
                rd_value[`STATUS_EMPTY_BIT] = itrng_empty;
                rd_value[`STATUS_FULL_BIT]  = itrng_full;
            end
            `REG_LOG_DATA: begin
                rd_value[$bits(fpga_wrapper_pkg::log_char_t)-1:0] = log_char;
                rd_value[`LOG_VALID_BIT] = !log_empty;
            end
            `REG_LOG_STATUS: begin
                rd_value[`STATUS_EMPTY_BIT] = log_empty;
                rd_value[`STATUS_FULL_BIT]  = log_full;
            end
            `REG_CYCLE_COUNT: begin
                rd_value = cycle_count;
            end
            default: begin
                rd_value = '0;
            end
        endcase
    end

    // Read data lands one cycle after the strobe
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rd_valid <= 1'b0;
            reg_rdata    <= '0;
        end else begin
            reg_rd_valid <= reg_rd_en;
            if (reg_rd_en) begin
                reg_rdata <= rd_value;
            end
        end
    end

    // Control and divisor registers
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            ctrl_itrng_clear <= 1'b0;
            divisor_q        <= '0;
        end else begin
            if (wr_control) begin
                ctrl_itrng_clear <= reg_wdata[`CTRL_ITRNG_CLEAR_BIT];
            end
            if (wr_divisor) begin
                divisor_q <= reg_wdata;
            end
        end
    end

    // Free-running cycle counter
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             core_clk,
    input  logic             hwif_out,
    input  logic             clear,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointers wrap at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head entry
    assign dout = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/fpga_wrapper_pkg.sv */
package fpga_wrapper_pkg;

    // Register strobe bus
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Console character from the core's generic output
    typedef logic [7:0]  log_char_t;

    // Entropy as written by software and as handed to the core
    typedef logic [31:0] trng_word_t;
    typedef logic [3:0]  trng_nibble_t;

    typedef logic [31:0] cycle_count_t;

    // Unpacker state
    typedef enum logic {
        TRNG_EMPTY,
        TRNG_SHIFT
    } trng_state_e;

endpackage

/* src/fpga_wrapper_consts.svh */
`ifndef FPGA_WRAPPER_CONSTS_SVH
`define FPGA_WRAPPER_CONSTS_SVH

// Register byte offsets
`define REG_CONTROL        8'h00
`define REG_ITRNG_DIVISOR  8'h04
`define REG_ITRNG_DATA     8'h08
`define REG_ITRNG_STATUS   8'h0C
`define REG_LOG_DATA       8'h10
`define REG_LOG_STATUS     8'h14
`define REG_CYCLE_COUNT    8'h18

// FIFO depths
`define LOG_FIFO_DEPTH     16
`define ITRNG_FIFO_DEPTH   8

// Field positions
`define NIBBLES_PER_WORD      8
`define LOG_VALID_BIT         8
`define CTRL_ITRNG_CLEAR_BIT  0
`define STATUS_EMPTY_BIT      0
`define STATUS_FULL_BIT       1

`endif
